// File: build.f
+incdir+.
i2c_bus_pkg.sv
wb_regs_pkg.sv
wb_cmd_decoder.sv
i2c_write_master.sv
i2c_status_collector.sv
i2c_cfg_top.sv
tb_i2c_slave_model.sv
tb_i2c_cfg_top.sv

// File: i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    // One register write on the bus
    typedef struct packed {
        logic [6:0] dev_addr;   // 7-bit target address
        logic [7:0] reg_addr;
        logic [7:0] value;
    } i2c_xfer_t;

    // Per-channel report from a byte master
    typedef struct packed {
        logic busy;     // Level, high for the whole transfer
        logic done;     // Single-cycle pulse at the end
        logic nack;     // Qualified by done
    } chan_status_t;

endpackage

`default_nettype wire

// File: i2c_cfg_params.svh
`ifndef I2C_CFG_PARAMS_SVH
`define I2C_CFG_PARAMS_SVH

// Number of independent I2C channels, 1 to 4
`define I2C_NUM_CHANNELS 2

// Host address of channel 0 command register
// Channel n sits at base+n, status clear right after the last channel
`define I2C_CMD_BASE 6'h3c

// SCL phase length in clk cycles minus one
`define I2C_RESET_PRESCALE 16'd4

// Command opcodes in bits 31:24 of the command word
`define I2C_OP_WRITE_REG    8'h06
`define I2C_OP_SET_PRESCALE 8'h07

`endif

// File: i2c_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_params.svh"

module i2c_cfg_top
    import i2c_bus_pkg::*;
    import wb_regs_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_i,
    input  host_wr_t                         host_i,
    input  logic [`I2C_NUM_CHANNELS-1:0]     scl_i,
    input  logic [`I2C_NUM_CHANNELS-1:0]     sda_i,
    output logic                             ack_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     scl_oe_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     sda_oe_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     busy_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     nack_flags_o,
    output logic                             irq_o
);

    localparam int NCH = `I2C_NUM_CHANNELS;

    logic [NCH-1:0] xfer_start;
    i2c_xfer_t      xfer;
    logic [NCH-1:0] prescale_load;
    logic [15:0]    prescale;
    logic           clear;
    chan_status_t   chan_status [NCH];

    wb_cmd_decoder u_decoder (
        .clk             (clk),
        .reset_i         (reset_i),
        .host_i          (host_i),
        .chan_status_i   (chan_status),
        .ack_o           (ack_o),
        .xfer_start_o    (xfer_start),
        .xfer_o          (xfer),
        .prescale_load_o (prescale_load),
        .prescale_o      (prescale),
        .clear_o         (clear)
    );

    // One byte master per channel, all on clk
    for (genvar i = 0; i < NCH; i++) begin : g_chan
        i2c_write_master u_master (
            .clk             (clk),
            .reset_i         (reset_i),
            .xfer_start_i    (xfer_start[i]),
            .xfer_i          (xfer),
            .prescale_load_i (prescale_load[i]),
            .prescale_i      (prescale),
            .scl_i           (scl_i[i]),
            .sda_i           (sda_i[i]),
            .scl_oe_o        (scl_oe_o[i]),
            .sda_oe_o        (sda_oe_o[i]),
            .status_o        (chan_status[i])
        );
    end

    i2c_status_collector u_collector (
        .clk           (clk),
        .reset_i       (reset_i),
        .chan_status_i (chan_status),
        .clear_i       (clear),
        .busy_o        (busy_o),
        .nack_flags_o  (nack_flags_o),
        .irq_o         (irq_o)
    );

endmodule

`default_nettype wire

// File: i2c_status_collector.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_params.svh"

module i2c_status_collector
    import i2c_bus_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_i,
    input  chan_status_t                     chan_status_i [`I2C_NUM_CHANNELS],
    input  logic                             clear_i,
    output logic [`I2C_NUM_CHANNELS-1:0]     busy_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     nack_flags_o,
    output logic                             irq_o
);

    localparam int NCH = `I2C_NUM_CHANNELS;

    logic [NCH-1:0] done_vec;
    logic [NCH-1:0] nack_set;

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            busy_o[i]   = chan_status_i[i].busy;
            done_vec[i] = chan_status_i[i].done;
            nack_set[i] = chan_status_i[i].done && chan_status_i[i].nack;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            irq_o        <= 1'b0;
            nack_flags_o <= '0;
        end else begin
            irq_o <= |done_vec;     // One pulse per completion cycle
            // New NACK wins over a clear in the same cycle
            nack_flags_o <= nack_set | (clear_i ? '0 : nack_flags_o);
        end
    end

endmodule

`default_nettype wire

// File: i2c_write_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_params.svh"

module i2c_write_master
    import i2c_bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  logic         xfer_start_i,
    input  i2c_xfer_t    xfer_i,
    input  logic         prescale_load_i,
    input  logic [15:0]  prescale_i,
    input  logic         scl_i,
    input  logic         sda_i,
    output logic         scl_oe_o,      // High pulls SCL low
    output logic         sda_oe_o,      // High pulls SDA low
    output chan_status_t status_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_BIT,
        ST_STOP
    } state_t;

    state_t      state;
    logic [1:0]  phase;         // Four phases per SCL bit
    logic [15:0] cnt;
    logic [15:0] prescale_q;
    logic [3:0]  bit_idx;       // 8 is the ACK slot
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic        nack_q;
    i2c_xfer_t   xfer_q;
    logic        stall;
    logic        tick;
    logic        ack_slot;
    logic        last_byte;
    logic [7:0]  next_byte;

    // SCL released but still low, so the target is stretching
    assign stall     = !scl_oe_o && !scl_i;
    assign tick      = (cnt >= prescale_q) && !stall;
    assign ack_slot  = (bit_idx == 4'd8);
    assign last_byte = (byte_idx == 2'd2);

    always_comb begin
        case (byte_idx)
            2'd0:    next_byte = xfer_q.reg_addr;
            default: next_byte = xfer_q.value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prescale_q <= `I2C_RESET_PRESCALE;
        end else if (prescale_load_i) begin
            prescale_q <= prescale_i;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_start_i) begin
            xfer_q <= xfer_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            phase    <= '0;
            cnt      <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            shreg    <= '0;
            nack_q   <= 1'b0;
            scl_oe_o <= 1'b0;
            sda_oe_o <= 1'b0;
            status_o <= '0;
        end else begin
            status_o.done <= 1'b0;
            status_o.nack <= 1'b0;
            if (state == ST_IDLE) begin
                cnt   <= '0;
                phase <= '0;
                if (xfer_start_i) begin
                    state         <= ST_START;
                    status_o.busy <= 1'b1;
                    bit_idx       <= '0;
                    byte_idx      <= '0;
                    nack_q        <= 1'b0;
                end
            end else if (!tick) begin
                if (!stall) begin
                    cnt <= cnt + 16'd1;
                end
            end else begin
                cnt   <= '0;
                phase <= phase + 2'd1;
                case (state)
                    ST_START: begin
                        if (phase == 2'd1) begin
                            sda_oe_o <= 1'b1;   // SDA falls while SCL high
                        end
                        if (phase == 2'd3) begin
                            scl_oe_o <= 1'b1;
                            shreg    <= {xfer_q.dev_addr, 1'b0};   // Write bit
                            state    <= ST_BIT;
                        end
                    end
                    ST_BIT: begin
                        case (phase)
                            2'd0: sda_oe_o <= ack_slot ? 1'b0 : !shreg[7];
                            2'd1: scl_oe_o <= 1'b0;
                            2'd2: begin
                                if (ack_slot && sda_i) begin
                                    nack_q <= 1'b1;
                                end
                            end
                            default: begin
                                scl_oe_o <= 1'b1;
                                if (!ack_slot) begin
                                    bit_idx <= bit_idx + 4'd1;
                                    shreg   <= {shreg[6:0], 1'b0};
                                end else begin
                                    bit_idx <= '0;
                                    if (nack_q || last_byte) begin
                                        state <= ST_STOP;
                                    end else begin
                                        byte_idx <= byte_idx + 2'd1;
                                        shreg    <= next_byte;
                                    end
                                end
                            end
                        endcase
                    end
                    ST_STOP: begin
                        case (phase)
                            2'd0: sda_oe_o <= 1'b1;
                            2'd1: scl_oe_o <= 1'b0;
                            2'd2: sda_oe_o <= 1'b0;    // SDA rises while SCL high
                            default: begin
                                state         <= ST_IDLE;
                                status_o.busy <= 1'b0;
                                status_o.done <= 1'b1;
                                status_o.nack <= nack_q;
                            end
                        endcase
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Decoder back-pressure keeps starts away from a running channel
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i)
        xfer_start_i |-> !status_o.busy);

    // Data bits may only move while SCL is held low
    a_sda_scl_low: assert property (@(posedge clk) disable iff (reset_i)
        ($changed(sda_oe_o) && $past(state) == ST_BIT) |-> (scl_oe_o && $past(scl_oe_o)));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_i2c_cfg_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_i2c_cfg_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1

// File: tb_i2c_cfg_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_params.svh"

module tb_i2c_cfg_top
    import i2c_bus_pkg::*;
    import wb_regs_pkg::*;
();

    localparam int NCH          = `I2C_NUM_CHANNELS;
    localparam int MAX_PRESCALE = 9;
    // Longer than the SCL low time so the master has to wait for release
    localparam int STRETCH      = 5 * (MAX_PRESCALE + 1);
    // START, 27 bits and STOP make 116 phases, plus a stretch per SCL low
    localparam int XFER_CYCLES  = 116 * (MAX_PRESCALE + 1) + 28 * STRETCH;
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = NUM_TESTS * 4 * XFER_CYCLES + 2000;
    localparam logic [6:0] ADDR0 = 7'h50;
    localparam logic [6:0] ADDR1 = 7'h51;

    logic           clk;
    logic           reset_i;
    host_wr_t       host;
    logic [NCH-1:0] stretch_en;
    wire  [NCH-1:0] scl_line;
    wire  [NCH-1:0] sda_line;
    wire            ack;
    wire  [NCH-1:0] scl_oe;
    wire  [NCH-1:0] sda_oe;
    wire  [NCH-1:0] busy;
    wire  [NCH-1:0] nack_flags;
    wire            irq;

    int   err_cnt;
    int   pass_tests;
    int   fail_tests;
    int   cycles;
    int   irq_cnt;
    int   seed;
    logic meas_on;
    logic scl1_q;
    logic in_run;
    int   high_run;
    int   high_q [$];     // SCL high lengths on channel 1

    i2c_cfg_top dut0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .host_i       (host),
        .scl_i        (scl_line),
        .sda_i        (sda_line),
        .ack_o        (ack),
        .scl_oe_o     (scl_oe),
        .sda_oe_o     (sda_oe),
        .busy_o       (busy),
        .nack_flags_o (nack_flags),
        .irq_o        (irq)
    );

    tb_i2c_slave_model #(.DEV_ADDR(ADDR0), .STRETCH_CYCLES(STRETCH)) slave0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .stretch_en_i (stretch_en[0]),
        .scl_oe_i     (scl_oe[0]),
        .sda_oe_i     (sda_oe[0]),
        .scl_o        (scl_line[0]),
        .sda_o        (sda_line[0])
    );

    tb_i2c_slave_model #(.DEV_ADDR(ADDR1), .STRETCH_CYCLES(STRETCH)) slave1 (
        .clk          (clk),
        .reset_i      (reset_i),
        .stretch_en_i (stretch_en[1]),
        .scl_oe_i     (scl_oe[1]),
        .sda_oe_i     (sda_oe[1]),
        .scl_o        (scl_line[1]),
        .sda_o        (sda_line[1])
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Cycle count, irq count and SCL high measurement
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (irq) begin
            irq_cnt <= irq_cnt + 1;
        end
        if (reset_i) begin
            scl1_q <= 1'b1;
            in_run <= 1'b0;
        end else begin
            scl1_q <= scl_line[1];
            if (scl_line[1] && !scl1_q) begin
                in_run   <= 1'b1;
                high_run <= 1;
            end else if (scl_line[1] && in_run) begin
                high_run <= high_run + 1;
            end else if (!scl_line[1] && scl1_q) begin
                if (in_run && meas_on) begin
                    high_q.push_back(high_run);
                end
                in_run <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (exp !== got) begin
            $display("Error %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic compare_flags(input string name, input logic [NCH-1:0] exp,
                                 input logic [NCH-1:0] got);
        if (exp !== got) begin
            $display("Error %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            $display("Error %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int got);
        if (exp != got) begin
            $display("Error %s expected %h got %h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_fail(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            pass_tests++;
            $display("Test %s: ok", name);
        end else begin
            fail_tests++;
            $display("Test %s: failed", name);
        end
    endtask

    function automatic logic [7:0] get_rx(input int ch, input int idx);
        return (ch == 0) ? slave0.rx_bytes[idx % 256] : slave1.rx_bytes[idx % 256];
    endfunction

    function automatic int get_rx_cnt(input int ch);
        return (ch == 0) ? slave0.rx_cnt : slave1.rx_cnt;
    endfunction

    function automatic int get_stop_cnt(input int ch);
        return (ch == 0) ? slave0.stop_cnt : slave1.stop_cnt;
    endfunction

    function automatic logic [31:0] xfer_cmd(input i2c_xfer_t x);
        cmd_word_u c;
        c.xfer.opcode   = `I2C_OP_WRITE_REG;
        c.xfer.rsvd     = 1'b0;
        c.xfer.dev_addr = x.dev_addr;
        c.xfer.reg_addr = x.reg_addr;
        c.xfer.value    = x.value;
        return c;
    endfunction

    function automatic logic [31:0] prescale_cmd(input logic [15:0] p);
        cmd_word_u c;
        c.cfg.opcode   = `I2C_OP_SET_PRESCALE;
        c.cfg.rsvd     = 8'h00;
        c.cfg.prescale = p;
        return c;
    endfunction

    task automatic make_xfer(input logic [6:0] addr, output i2c_xfer_t x);
        x.dev_addr = addr;
        x.reg_addr = 8'($random(seed));
        x.value    = 8'($random(seed));
    endtask

    // Holds stb until ack, tracks the target's busy level
    task automatic host_write(input logic [5:0] addr, input logic [31:0] data,
                              input logic is_xfer, output logic busy_seen);
        host_wr_t h;
        int       n;
        logic     prev_busy;
        logic     acked;
        logic [5:0] off;
        h.addr    = addr;
        h.data    = data;
        h.we      = 1'b1;
        h.stb     = 1'b1;
        n         = 0;
        acked     = 1'b0;
        prev_busy = 1'b0;
        busy_seen = 1'b0;
        off       = addr - `I2C_CMD_BASE;
        @(posedge clk);
        host <= h;
        while (!acked && n < XFER_CYCLES) begin
            @(posedge clk);
            n++;
            if (ack) begin
                host  <= '0;
                acked = 1'b1;
                if (is_xfer && prev_busy) begin
                    report_fail("Write accepted while the target channel was busy");
                end
            end else begin
                prev_busy = 1'b0;
                for (int i = 0; i < NCH; i++) begin
                    if (off == 6'(i)) prev_busy = busy[i];
                end
                if (prev_busy) busy_seen = 1'b1;
            end
        end
        if (!acked) begin
            host <= '0;
            report_fail($sformatf("No ack came for the write to address %h", addr));
        end
    endtask

    task automatic wait_done(input int ch);
        int   n;
        logic seen;
        logic finished;
        n        = 0;
        seen     = 1'b0;
        finished = 1'b0;
        while (!finished && n < XFER_CYCLES) begin
            @(posedge clk);
            n++;
            if (busy[ch]) seen = 1'b1;
            else if (seen) finished = 1'b1;
        end
        if (!finished) begin
            report_fail($sformatf("Channel %0d never finished its transfer", ch));
        end
        repeat (2) @(posedge clk);      // Collector latency
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        repeat (2) @(posedge clk);
        while (busy != '0 && n < 2 * XFER_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (busy != '0) begin
            report_fail("Channels stayed busy too long");
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic check_xfer(input int ch, input int base, input i2c_xfer_t x);
        compare_byte("rx_addr_byte", {x.dev_addr, 1'b0}, get_rx(ch, base));
        compare_byte("rx_reg_byte", x.reg_addr, get_rx(ch, base + 1));
        compare_byte("rx_value_byte", x.value, get_rx(ch, base + 2));
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_cnt;
        compare_bit("ack_o", 1'b0, ack);
        compare_bit("irq_o", 1'b0, irq);
        compare_flags("busy_o", '0, busy);
        compare_flags("nack_flags_o", '0, nack_flags);
        compare_flags("scl_oe_o", '0, scl_oe);
        compare_flags("sda_oe_o", '0, sda_oe);
        finish_test("reset", e0);
    endtask

    task automatic test_write_ch0();
        int        e0;
        int        base;
        int        irq0;
        logic      bs;
        i2c_xfer_t x;
        e0 = err_cnt;
        make_xfer(ADDR0, x);
        base = get_rx_cnt(0);
        irq0 = irq_cnt;
        host_write(6'(`I2C_CMD_BASE), xfer_cmd(x), 1'b1, bs);
        wait_done(0);
        compare_count("rx_count", 3, get_rx_cnt(0) - base);
        check_xfer(0, base, x);
        compare_bit("irq_o", 1'b1, irq_cnt == irq0 + 1);
        compare_flags("nack_flags_o", '0, nack_flags);
        finish_test("write_ch0", e0);
    endtask

    task automatic test_prescale();
        int        e0;
        int        base;
        logic      bs;
        i2c_xfer_t x;
        e0 = err_cnt;
        host_write(6'(`I2C_CMD_BASE + 1), prescale_cmd(16'(MAX_PRESCALE)), 1'b0, bs);
        high_q.delete();
        meas_on <= 1'b1;
        make_xfer(ADDR1, x);
        base = get_rx_cnt(1);
        host_write(6'(`I2C_CMD_BASE + 1), xfer_cmd(x), 1'b1, bs);
        wait_done(1);
        meas_on <= 1'b0;
        check_xfer(1, base, x);
        compare_count("scl_high_count", 27, high_q.size());
        foreach (high_q[i]) begin
            compare_count("scl_high_cycles", 2 * (MAX_PRESCALE + 1), high_q[i]);
        end
        // Same channel with the target holding SCL low
        stretch_en <= 2'b10;
        make_xfer(ADDR1, x);
        base = get_rx_cnt(1);
        host_write(6'(`I2C_CMD_BASE + 1), xfer_cmd(x), 1'b1, bs);
        wait_done(1);
        stretch_en <= '0;
        compare_count("rx_count", 3, get_rx_cnt(1) - base);
        check_xfer(1, base, x);
        finish_test("prescale", e0);
    endtask

    task automatic test_nack();
        int        e0;
        int        base;
        int        stop0;
        logic      bs;
        i2c_xfer_t x;
        e0 = err_cnt;
        make_xfer(7'h21, x);            // No target at this address
        base  = get_rx_cnt(0);
        stop0 = get_stop_cnt(0);
        host_write(6'(`I2C_CMD_BASE), xfer_cmd(x), 1'b1, bs);
        wait_done(0);
        compare_count("rx_count", 1, get_rx_cnt(0) - base);
        compare_byte("rx_addr_byte", {x.dev_addr, 1'b0}, get_rx(0, base));
        compare_flags("nack_flags_o", NCH'(1), nack_flags);
        compare_count("stop_count", 1, get_stop_cnt(0) - stop0);
        host_write(6'(`I2C_CMD_BASE + NCH), 32'h0, 1'b0, bs);
        repeat (2) @(posedge clk);
        compare_flags("nack_flags_o", '0, nack_flags);
        finish_test("nack", e0);
    endtask

    task automatic test_backpressure();
        int        e0;
        int        base0;
        int        base1;
        logic      bs;
        i2c_xfer_t x1;
        i2c_xfer_t x2;
        e0 = err_cnt;
        make_xfer(ADDR0, x1);
        make_xfer(ADDR0, x2);
        base0 = get_rx_cnt(0);
        host_write(6'(`I2C_CMD_BASE), xfer_cmd(x1), 1'b1, bs);
        host_write(6'(`I2C_CMD_BASE), xfer_cmd(x2), 1'b1, bs);
        compare_bit("busy_o_during_wait", 1'b1, bs);
        wait_done(0);
        check_xfer(0, base0, x1);
        check_xfer(0, base0 + 3, x2);
        // Both channels at once
        make_xfer(ADDR0, x1);
        make_xfer(ADDR1, x2);
        base0 = get_rx_cnt(0);
        base1 = get_rx_cnt(1);
        host_write(6'(`I2C_CMD_BASE), xfer_cmd(x1), 1'b1, bs);
        host_write(6'(`I2C_CMD_BASE + 1), xfer_cmd(x2), 1'b1, bs);
        wait_idle();
        check_xfer(0, base0, x1);
        check_xfer(1, base1, x2);
        compare_flags("nack_flags_o", '0, nack_flags);
        finish_test("backpressure", e0);
    endtask

    task automatic test_unknown_op();
        int             e0;
        logic           bs;
        logic [NCH-1:0] scl_any;
        logic [NCH-1:0] sda_any;
        logic [NCH-1:0] busy_any;
        e0       = err_cnt;
        scl_any  = '0;
        sda_any  = '0;
        busy_any = '0;
        host_write(6'(`I2C_CMD_BASE), 32'h3312_3456, 1'b0, bs);
        repeat (100) begin
            @(posedge clk);
            scl_any  = scl_any | scl_oe;
            sda_any  = sda_any | sda_oe;
            busy_any = busy_any | busy;
        end
        compare_flags("scl_oe_o", '0, scl_any);
        compare_flags("sda_oe_o", '0, sda_any);
        compare_flags("busy_o", '0, busy_any);
        finish_test("unknown_op", e0);
    endtask

    initial begin
        seed       = 13;
        host       = '0;
        reset_i    = 1'b1;
        stretch_en = '0;
        meas_on    = 1'b0;
        err_cnt    = 0;
        pass_tests = 0;
        fail_tests = 0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        test_reset();
        test_write_ch0();
        test_prescale();
        test_nack();
        test_backpressure();
        test_unknown_op();
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 pass_tests, fail_tests, err_cnt);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR       = 7'h50,
    parameter int         STRETCH_CYCLES = 20
) (
    input  logic clk,
    input  logic reset_i,
    input  logic stretch_en_i,
    input  logic scl_oe_i,      // Master pull-low enables
    input  logic sda_oe_i,
    output logic scl_o,         // Resolved open-drain lines
    output logic sda_o
);

    logic       s_scl_oe;
    logic       s_sda_oe;
    logic       scl_q;
    logic       sda_q;
    logic [7:0] shreg;
    logic       in_ack;
    logic       ack_q;
    logic       addressed;
    logic       first_byte;
    int         bit_cnt;
    int         stretch_cnt;

    // Capture log read by the testbench
    logic [7:0] rx_bytes [256];
    int         rx_cnt;
    int         stop_cnt;

    // Wire-AND of master and target
    assign scl_o = !(scl_oe_i || s_scl_oe);
    assign sda_o = !(sda_oe_i || s_sda_oe);

    always @(posedge clk) begin
        logic [7:0] rx_byte;
        if (reset_i) begin
            s_scl_oe    <= 1'b0;
            s_sda_oe    <= 1'b0;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            shreg       <= '0;
            in_ack      <= 1'b0;
            ack_q       <= 1'b0;
            addressed   <= 1'b0;
            first_byte  <= 1'b0;
            bit_cnt     <= 0;
            stretch_cnt <= 0;
            rx_cnt      <= 0;
            stop_cnt    <= 0;
        end else begin
            scl_q <= scl_o;
            sda_q <= sda_o;
            if (stretch_cnt > 0) begin
                stretch_cnt <= stretch_cnt - 1;
                if (stretch_cnt == 1) begin
                    s_scl_oe <= 1'b0;
                end
            end
            if (scl_o && scl_q && sda_q && !sda_o) begin
                bit_cnt    <= 0;                 // START
                in_ack     <= 1'b0;
                first_byte <= 1'b1;
                addressed  <= 1'b0;
                s_sda_oe   <= 1'b0;
            end else if (scl_o && scl_q && !sda_q && sda_o) begin
                stop_cnt  <= stop_cnt + 1;       // STOP
                addressed <= 1'b0;
                bit_cnt   <= 0;
                in_ack    <= 1'b0;
            end else if (scl_o && !scl_q) begin
                if (bit_cnt < 8) begin
                    rx_byte = {shreg[6:0], sda_o};
                    shreg   <= rx_byte;
                    bit_cnt <= bit_cnt + 1;
                    if (bit_cnt == 7) begin
                        rx_bytes[rx_cnt % 256] <= rx_byte;
                        rx_cnt <= rx_cnt + 1;
                        if (first_byte) begin
                            // Address byte with write bit
                            addressed  <= (rx_byte[7:1] == DEV_ADDR) && !rx_byte[0];
                            ack_q      <= (rx_byte[7:1] == DEV_ADDR) && !rx_byte[0];
                            first_byte <= 1'b0;
                        end else begin
                            ack_q <= addressed;
                        end
                    end
                end
            end else if (!scl_o && scl_q) begin
                if (stretch_en_i) begin
                    s_scl_oe    <= 1'b1;
                    stretch_cnt <= STRETCH_CYCLES;
                end
                if (bit_cnt == 8 && !in_ack) begin
                    in_ack   <= 1'b1;
                    s_sda_oe <= ack_q;           // ACK slot starts
                end else if (in_ack) begin
                    in_ack   <= 1'b0;
                    s_sda_oe <= 1'b0;
                    bit_cnt  <= 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: wb_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2c_cfg_params.svh"

module wb_cmd_decoder
    import i2c_bus_pkg::*;
    import wb_regs_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_i,
    input  host_wr_t                         host_i,
    input  chan_status_t                     chan_status_i [`I2C_NUM_CHANNELS],
    output logic                             ack_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     xfer_start_o,
    output i2c_xfer_t                        xfer_o,
    output logic [`I2C_NUM_CHANNELS-1:0]     prescale_load_o,
    output logic [15:0]                      prescale_o,
    output logic                             clear_o
);

    localparam int NCH = `I2C_NUM_CHANNELS;

    cmd_word_u      cmd;
    logic [7:0]     opcode;
    logic [5:0]     offset;
    logic [NCH-1:0] chan_hit;
    logic [NCH-1:0] chan_busy;
    logic           clear_hit;
    logic           is_write_reg;
    logic           is_set_prescale;
    logic           blocked;
    logic           accept;

    assign cmd    = host_i.data;
    assign opcode = cmd.xfer.opcode;    // Same bits in both views
    assign offset = host_i.addr - `I2C_CMD_BASE;   // Below base wraps out of range

    always_comb begin
        for (int i = 0; i < NCH; i++) begin
            chan_hit[i]  = (offset == 6'(i));
            chan_busy[i] = chan_status_i[i].busy;
        end
    end

    assign clear_hit       = (offset == 6'(NCH));
    assign is_write_reg    = (opcode == `I2C_OP_WRITE_REG);
    assign is_set_prescale = (opcode == `I2C_OP_SET_PRESCALE);

    // Hold off a new transfer until the target channel is free
    assign blocked = is_write_reg && |(chan_hit & chan_busy);
    assign accept  = host_i.stb && host_i.we && !ack_o && !blocked;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o           <= 1'b0;
            xfer_start_o    <= '0;
            prescale_load_o <= '0;
            clear_o         <= 1'b0;
        end else begin
            ack_o           <= accept;
            xfer_start_o    <= (accept && is_write_reg) ? chan_hit : '0;
            prescale_load_o <= (accept && is_set_prescale) ? chan_hit : '0;
            clear_o         <= accept && clear_hit;
        end
    end

    // Shared by all channels, only the started one latches it
    always_ff @(posedge clk) begin
        if (accept) begin
            xfer_o.dev_addr <= cmd.xfer.dev_addr;
            xfer_o.reg_addr <= cmd.xfer.reg_addr;
            xfer_o.value    <= cmd.xfer.value;
            prescale_o      <= cmd.cfg.prescale;
        end
    end

    // Host must see ack drop before a write can be taken again
    a_ack_single: assert property (@(posedge clk) disable iff (reset_i)
        ack_o |=> !ack_o);

    a_start_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(xfer_start_o));

endmodule

`default_nettype wire

// File: wb_regs_pkg.sv
`default_nettype none

package wb_regs_pkg;

    // Command word seen as a register write
    typedef struct packed {
        logic [7:0] opcode;
        logic       rsvd;       // Bit 23
        logic [6:0] dev_addr;
        logic [7:0] reg_addr;
        logic [7:0] value;
    } cmd_xfer_view_t;

    // Command word seen as a channel setting
    typedef struct packed {
        logic [7:0]  opcode;
        logic [7:0]  rsvd;
        logic [15:0] prescale;
    } cmd_cfg_view_t;

    // Opcode picks which view applies
    typedef union packed {
        cmd_xfer_view_t xfer;
        cmd_cfg_view_t  cfg;
    } cmd_word_u;

    // Host write port, held until ack
    typedef struct packed {
        logic [5:0] addr;
        cmd_word_u  data;
        logic       we;
        logic       stb;
    } host_wr_t;

endpackage

`default_nettype wire
